// ==== filelist.f ====
src/eth_stats_pkg.sv
src/eth_regs_pkg.sv
src/eth_stats_if.sv
src/eth_frame_counter_tx.sv
src/eth_frame_counter_rx.sv
src/eth_stats_adder.sv
src/eth_stats_regs.sv
src/eth_stats_log.sv
src/eth_stats_collector.sv
verification/tb_clock_gen.sv
verification/tb_eth_stats.sv

// ==== src/eth_frame_counter_rx.sv ====
// The MAC never stalls rx, so every valid beat is one byte; tuser flags a bad frame

`timescale 1ns/100ps

module eth_frame_counter_rx (
	input logic clk,
	input logic rst_n,
	input logic axis_rx_tvalid,
	input logic axis_rx_tlast,
	input logic axis_rx_tuser,
	output logic [eth_stats_pkg::LEN_WIDTH-1:0] frame_bytes,
	output logic frame_good,
	output logic valid
);

	logic [eth_stats_pkg::LEN_WIDTH-1:0] beat_count;
	logic [eth_stats_pkg::LEN_WIDTH-1:0] length;

	assign length = beat_count + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat_count <= '0;
			valid <= 1'b0;
		end else begin
			valid <= axis_rx_tvalid && axis_rx_tlast;
			if (axis_rx_tvalid) begin
				beat_count <= axis_rx_tlast ? '0 : length;
			end
		end
	end

	// Verdict comes straight from the MAC on the last beat
	always_ff @(posedge clk) begin
		if (axis_rx_tvalid && axis_rx_tlast) begin
			frame_bytes <= length;
			frame_good <= !axis_rx_tuser;
		end
	end

endmodule

// ==== src/eth_frame_counter_tx.sv ====
// One byte per accepted beat is assumed; frames longer than 17 bits of bytes wrap

`timescale 1ns/100ps

module eth_frame_counter_tx (
	input logic clk,
	input logic rst_n,
	input logic axis_tx_tvalid,
	input logic axis_tx_tready,
	input logic axis_tx_tlast,
	output logic [eth_stats_pkg::LEN_WIDTH-1:0] frame_bytes,
	output logic frame_good,
	output logic valid
);

	logic [eth_stats_pkg::LEN_WIDTH-1:0] beat_count;
	logic [eth_stats_pkg::LEN_WIDTH-1:0] length;
	logic beat;

	assign beat = axis_tx_tvalid && axis_tx_tready;
	// Includes the current beat
	assign length = beat_count + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			beat_count <= '0;
			valid <= 1'b0;
		end else begin
			valid <= beat && axis_tx_tlast;
			if (beat) begin
				beat_count <= axis_tx_tlast ? '0 : length;
			end
		end
	end

	// Report is payload, no reset needed
	always_ff @(posedge clk) begin
		if (beat && axis_tx_tlast) begin
			frame_bytes <= length;
			frame_good <= (length >= eth_stats_pkg::MIN_FRAME_LEN) &&
				(length <= eth_stats_pkg::MAX_FRAME_LEN);
		end
	end

	a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		valid |=> !valid);

endmodule

// ==== src/eth_regs_pkg.sv ====
// AXI4-Lite register map; write strobes and protection bits are not decoded

package eth_regs_pkg;

	localparam int unsigned ADDR_WIDTH = 12;
	localparam int unsigned DATA_WIDTH = 32;

	// Control bits
	localparam int unsigned CTRL_ENABLE = 0;
	localparam int unsigned CTRL_SRST = 1;

	localparam logic [ADDR_WIDTH-1:0] REG_CTRL = 12'h000;
	localparam logic [ADDR_WIDTH-1:0] REG_SAMPLE_PERIOD = 12'h004;
	localparam logic [ADDR_WIDTH-1:0] REG_OVERFLOW_LO = 12'h008;
	localparam logic [ADDR_WIDTH-1:0] REG_OVERFLOW_HI = 12'h00C;

	// Read-only counter view
	localparam logic [ADDR_WIDTH-1:0] REG_TX_BYTES_LO = 12'h010;
	localparam logic [ADDR_WIDTH-1:0] REG_TX_BYTES_HI = 12'h014;
	localparam logic [ADDR_WIDTH-1:0] REG_TX_GOOD_LO = 12'h018;
	localparam logic [ADDR_WIDTH-1:0] REG_TX_GOOD_HI = 12'h01C;
	localparam logic [ADDR_WIDTH-1:0] REG_TX_BAD_LO = 12'h020;
	localparam logic [ADDR_WIDTH-1:0] REG_TX_BAD_HI = 12'h024;
	localparam logic [ADDR_WIDTH-1:0] REG_RX_BYTES_LO = 12'h028;
	localparam logic [ADDR_WIDTH-1:0] REG_RX_BYTES_HI = 12'h02C;
	localparam logic [ADDR_WIDTH-1:0] REG_RX_GOOD_LO = 12'h030;
	localparam logic [ADDR_WIDTH-1:0] REG_RX_GOOD_HI = 12'h034;
	localparam logic [ADDR_WIDTH-1:0] REG_RX_BAD_LO = 12'h038;
	localparam logic [ADDR_WIDTH-1:0] REG_RX_BAD_HI = 12'h03C;

	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	typedef enum logic {
		BUS_IDLE,
		BUS_RESP
	} bus_state_t;

endpackage

// ==== src/eth_stats_adder.sv ====
// Totals wrap at 64 bits; srst clears the totals but leaves the change counter running

`timescale 1ns/100ps

module eth_stats_adder (
	input logic clk,
	input logic rst_n,
	input logic srst,
	input logic enable,
	input logic valid,
	input logic frame_good,
	input logic [eth_stats_pkg::LEN_WIDTH-1:0] frame_length,
	eth_stats_if.source stats
);

	logic [eth_stats_pkg::STAT_WIDTH-1:0] frames;
	logic count;

	assign count = valid && enable;
	assign frames = stats.total_good + stats.total_bad;

	always_ff @(posedge clk) begin
		if (!rst_n || srst) begin
			stats.total_bytes <= '0;
			stats.total_good <= '0;
			stats.total_bad <= '0;
		end else if (count) begin
			stats.total_bytes <= stats.total_bytes + frame_length;
			if (frame_good) begin
				stats.total_good <= stats.total_good + 1'b1;
			end else begin
				stats.total_bad <= stats.total_bad + 1'b1;
			end
		end
	end

	// Change counter for the logger, wraps freely
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			stats.stats_id <= '0;
		end else if (count) begin
			stats.stats_id <= stats.stats_id + 1'b1;
		end
	end

	a_one_frame: assert property (@(posedge clk) disable iff (!rst_n)
		!srst |=> frames <= $past(frames) + 1'b1);

endmodule

// ==== src/eth_stats_collector.sv ====
// Tx, rx and bus all share clk; one byte per stream beat; strobes and protection are not ported

`timescale 1ns/100ps

module eth_stats_collector (
	input logic clk,
	input logic rst_n,
	input logic [eth_stats_pkg::STAT_WIDTH-1:0] current_time,
	input logic time_running,

	// AXI4-Lite slave
	input logic [eth_regs_pkg::ADDR_WIDTH-1:0] s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [eth_regs_pkg::DATA_WIDTH-1:0] s_axi_wdata,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [eth_regs_pkg::ADDR_WIDTH-1:0] s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [eth_regs_pkg::DATA_WIDTH-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,

	// Log stream
	output logic [eth_stats_pkg::STAT_WIDTH-1:0] m_axis_log_tdata,
	output logic m_axis_log_tlast,
	output logic m_axis_log_tvalid,
	input logic m_axis_log_tready,

	// Monitored MAC streams
	input logic axis_tx_tvalid,
	input logic axis_tx_tready,
	input logic axis_tx_tlast,
	input logic axis_rx_tvalid,
	input logic axis_rx_tlast,
	input logic axis_rx_tuser
);

	logic enable;
	logic enable_q;
	logic srst;
	logic [eth_stats_pkg::TIMER_WIDTH-1:0] sample_period;
	logic [eth_stats_pkg::STAT_WIDTH-1:0] overflow_count;
	logic [eth_stats_pkg::LEN_WIDTH-1:0] tx_frame_bytes;
	logic [eth_stats_pkg::LEN_WIDTH-1:0] rx_frame_bytes;
	logic tx_frame_good;
	logic rx_frame_good;
	logic tx_valid;
	logic rx_valid;

	eth_stats_if tx_stats ();
	eth_stats_if rx_stats ();

	// Counting only while the host enables it and the time base runs
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enable_q <= 1'b0;
		end else begin
			enable_q <= enable && time_running;
		end
	end

	eth_frame_counter_tx u_tx_counter (
		.clk(clk),
		.rst_n(rst_n),
		.axis_tx_tvalid(axis_tx_tvalid),
		.axis_tx_tready(axis_tx_tready),
		.axis_tx_tlast(axis_tx_tlast),
		.frame_bytes(tx_frame_bytes),
		.frame_good(tx_frame_good),
		.valid(tx_valid)
	);

	eth_frame_counter_rx u_rx_counter (
		.clk(clk),
		.rst_n(rst_n),
		.axis_rx_tvalid(axis_rx_tvalid),
		.axis_rx_tlast(axis_rx_tlast),
		.axis_rx_tuser(axis_rx_tuser),
		.frame_bytes(rx_frame_bytes),
		.frame_good(rx_frame_good),
		.valid(rx_valid)
	);

	eth_stats_adder u_tx_adder (
		.clk(clk),
		.rst_n(rst_n),
		.srst(srst),
		.enable(enable_q),
		.valid(tx_valid),
		.frame_good(tx_frame_good),
		.frame_length(tx_frame_bytes),
		.stats(tx_stats.source)
	);

	eth_stats_adder u_rx_adder (
		.clk(clk),
		.rst_n(rst_n),
		.srst(srst),
		.enable(enable_q),
		.valid(rx_valid),
		.frame_good(rx_frame_good),
		.frame_length(rx_frame_bytes),
		.stats(rx_stats.source)
	);

	eth_stats_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.s_axi_awaddr(s_axi_awaddr),
		.s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready),
		.s_axi_wdata(s_axi_wdata),
		.s_axi_wvalid(s_axi_wvalid),
		.s_axi_wready(s_axi_wready),
		.s_axi_bresp(s_axi_bresp),
		.s_axi_bvalid(s_axi_bvalid),
		.s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr),
		.s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready),
		.s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp),
		.s_axi_rvalid(s_axi_rvalid),
		.s_axi_rready(s_axi_rready),
		.tx_stats(tx_stats.sink),
		.rx_stats(rx_stats.sink),
		.overflow_count(overflow_count),
		.enable(enable),
		.srst(srst),
		.sample_period(sample_period)
	);

	eth_stats_log u_log (
		.clk(clk),
		.rst_n(rst_n),
		.srst(srst),
		.sample_period(sample_period),
		.current_time(current_time),
		.tx_stats(tx_stats.sink),
		.rx_stats(rx_stats.sink),
		.overflow_count(overflow_count),
		.m_axis_log_tdata(m_axis_log_tdata),
		.m_axis_log_tlast(m_axis_log_tlast),
		.m_axis_log_tvalid(m_axis_log_tvalid),
		.m_axis_log_tready(m_axis_log_tready)
	);

endmodule

// ==== src/eth_stats_if.sv ====
// Totals of one traffic direction, all in the clk domain; stats_id wraps every eight frames

`timescale 1ns/100ps

interface eth_stats_if;

	logic [eth_stats_pkg::STAT_WIDTH-1:0] total_bytes;
	logic [eth_stats_pkg::STAT_WIDTH-1:0] total_good;
	logic [eth_stats_pkg::STAT_WIDTH-1:0] total_bad;
	// Bumped on every counted frame
	logic [eth_stats_pkg::ID_WIDTH-1:0] stats_id;

	modport source (
		output total_bytes, total_good, total_bad, stats_id
	);

	modport sink (
		input total_bytes, total_good, total_bad, stats_id
	);

endinterface

// ==== src/eth_stats_log.sv ====
// Good and bad counts are cut to 32 bits in the record; a trigger during a record is dropped

`timescale 1ns/100ps

module eth_stats_log (
	input logic clk,
	input logic rst_n,
	input logic srst,
	input logic [eth_stats_pkg::TIMER_WIDTH-1:0] sample_period,
	input logic [eth_stats_pkg::STAT_WIDTH-1:0] current_time,
	eth_stats_if.sink tx_stats,
	eth_stats_if.sink rx_stats,
	output logic [eth_stats_pkg::STAT_WIDTH-1:0] overflow_count,
	output logic [eth_stats_pkg::STAT_WIDTH-1:0] m_axis_log_tdata,
	output logic m_axis_log_tlast,
	output logic m_axis_log_tvalid,
	input logic m_axis_log_tready
);

	eth_stats_pkg::log_state_t state;
	logic [eth_stats_pkg::BEAT_WIDTH-1:0] beat;
	logic [eth_stats_pkg::STAT_WIDTH-1:0] snapshot [eth_stats_pkg::LOG_BEATS];
	logic [eth_stats_pkg::TIMER_WIDTH-1:0] sample_timer;
	logic [2*eth_stats_pkg::ID_WIDTH-1:0] id_now;
	logic [2*eth_stats_pkg::ID_WIDTH-1:0] id_prev;
	logic trigger;
	logic start;

	assign id_now = {tx_stats.stats_id, rx_stats.stats_id};
	assign start = trigger && (state == eth_stats_pkg::LOG_IDLE);

	// Change detection gated by the sample period
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_prev <= '0;
			trigger <= 1'b0;
		end else begin
			id_prev <= id_now;
			trigger <= (id_now != id_prev) && (sample_timer >= sample_period);
		end
	end

	// Saturates instead of wrapping
	always_ff @(posedge clk) begin
		if (!rst_n || srst || start) begin
			sample_timer <= '0;
		end else if (!(&sample_timer)) begin
			sample_timer <= sample_timer + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || srst) begin
			overflow_count <= '0;
		end else if (trigger && state == eth_stats_pkg::LOG_SEND) begin
			overflow_count <= overflow_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			snapshot[eth_stats_pkg::BEAT_TIME] <= current_time;
			snapshot[eth_stats_pkg::BEAT_TX_BYTES] <= tx_stats.total_bytes;
			snapshot[eth_stats_pkg::BEAT_TX_FRAMES] <=
				{tx_stats.total_good[31:0], tx_stats.total_bad[31:0]};
			snapshot[eth_stats_pkg::BEAT_RX_BYTES] <= rx_stats.total_bytes;
			snapshot[eth_stats_pkg::BEAT_RX_FRAMES] <=
				{rx_stats.total_good[31:0], rx_stats.total_bad[31:0]};
		end
	end

	// Beat sequencer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= eth_stats_pkg::LOG_IDLE;
			beat <= '0;
		end else begin
			case (state)
				eth_stats_pkg::LOG_IDLE: begin
					if (trigger) begin
						state <= eth_stats_pkg::LOG_SEND;
						beat <= '0;
					end
				end
				eth_stats_pkg::LOG_SEND: begin
					if (m_axis_log_tready) begin
						if (m_axis_log_tlast) begin
							state <= eth_stats_pkg::LOG_IDLE;
						end
						beat <= beat + 1'b1;
					end
				end
			endcase
		end
	end

	assign m_axis_log_tvalid = (state == eth_stats_pkg::LOG_SEND);
	assign m_axis_log_tlast = m_axis_log_tvalid && (beat == eth_stats_pkg::LOG_BEATS - 1);
	assign m_axis_log_tdata = snapshot[beat];

	a_tdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
		m_axis_log_tvalid && !m_axis_log_tready |=> $stable(m_axis_log_tdata));

endmodule

// ==== src/eth_stats_pkg.sv ====
// Widths and log layout for the one built configuration, in which every total is 64 bits wide

package eth_stats_pkg;

	// Totals and frame lengths
	localparam int unsigned STAT_WIDTH = 64;
	localparam int unsigned LEN_WIDTH = 17;
	localparam int unsigned ID_WIDTH = 3;
	localparam int unsigned TIMER_WIDTH = 32;

	// Good tx frames lie inside these bounds, both ends included
	localparam int unsigned MIN_FRAME_LEN = 60;
	localparam int unsigned MAX_FRAME_LEN = 1514;

	// One log record is five 64-bit beats
	localparam int unsigned LOG_BEATS = 5;
	localparam int unsigned BEAT_WIDTH = $clog2(LOG_BEATS);

	// Beat order within a record
	localparam int unsigned BEAT_TIME = 0;
	localparam int unsigned BEAT_TX_BYTES = 1;
	// Good count in the upper half, bad count in the lower half
	localparam int unsigned BEAT_TX_FRAMES = 2;
	localparam int unsigned BEAT_RX_BYTES = 3;
	localparam int unsigned BEAT_RX_FRAMES = 4;

	typedef enum logic {
		LOG_IDLE,
		LOG_SEND
	} log_state_t;

endpackage

// ==== src/eth_stats_regs.sv ====
// Single outstanding transaction per channel; writes to read-only counters are ignored

`timescale 1ns/100ps

module eth_stats_regs (
	input logic clk,
	input logic rst_n,
	input logic [eth_regs_pkg::ADDR_WIDTH-1:0] s_axi_awaddr,
	input logic s_axi_awvalid,
	output logic s_axi_awready,
	input logic [eth_regs_pkg::DATA_WIDTH-1:0] s_axi_wdata,
	input logic s_axi_wvalid,
	output logic s_axi_wready,
	output logic [1:0] s_axi_bresp,
	output logic s_axi_bvalid,
	input logic s_axi_bready,
	input logic [eth_regs_pkg::ADDR_WIDTH-1:0] s_axi_araddr,
	input logic s_axi_arvalid,
	output logic s_axi_arready,
	output logic [eth_regs_pkg::DATA_WIDTH-1:0] s_axi_rdata,
	output logic [1:0] s_axi_rresp,
	output logic s_axi_rvalid,
	input logic s_axi_rready,
	eth_stats_if.sink tx_stats,
	eth_stats_if.sink rx_stats,
	input logic [eth_stats_pkg::STAT_WIDTH-1:0] overflow_count,
	output logic enable,
	output logic srst,
	output logic [eth_stats_pkg::TIMER_WIDTH-1:0] sample_period
);

	eth_regs_pkg::bus_state_t wr_state;
	eth_regs_pkg::bus_state_t rd_state;
	logic wr_accept;
	logic wr_mapped;
	logic rd_accept;
	logic rd_mapped;
	logic [eth_regs_pkg::DATA_WIDTH-1:0] rd_word;

	assign wr_accept = (wr_state == eth_regs_pkg::BUS_IDLE) && s_axi_awvalid && s_axi_wvalid;
	assign s_axi_awready = wr_accept;
	assign s_axi_wready = wr_accept;
	assign s_axi_bvalid = (wr_state == eth_regs_pkg::BUS_RESP);

	assign rd_accept = (rd_state == eth_regs_pkg::BUS_IDLE) && s_axi_arvalid;
	assign s_axi_arready = rd_accept;
	assign s_axi_rvalid = (rd_state == eth_regs_pkg::BUS_RESP);

	// Map is contiguous and word aligned
	assign wr_mapped = (s_axi_awaddr <= eth_regs_pkg::REG_RX_BAD_HI) &&
		(s_axi_awaddr[1:0] == 2'b00);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_state <= eth_regs_pkg::BUS_IDLE;
			enable <= 1'b0;
			srst <= 1'b0;
			sample_period <= '0;
		end else begin
			srst <= 1'b0;
			case (wr_state)
				eth_regs_pkg::BUS_IDLE: begin
					if (wr_accept) begin
						wr_state <= eth_regs_pkg::BUS_RESP;
						if (s_axi_awaddr == eth_regs_pkg::REG_CTRL) begin
							enable <= s_axi_wdata[eth_regs_pkg::CTRL_ENABLE];
							srst <= s_axi_wdata[eth_regs_pkg::CTRL_SRST];
						end
						if (s_axi_awaddr == eth_regs_pkg::REG_SAMPLE_PERIOD) begin
							sample_period <= s_axi_wdata;
						end
					end
				end
				eth_regs_pkg::BUS_RESP: begin
					if (s_axi_bready) begin
						wr_state <= eth_regs_pkg::BUS_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			s_axi_bresp <= wr_mapped ? eth_regs_pkg::RESP_OKAY : eth_regs_pkg::RESP_SLVERR;
		end
	end

	// Read mux, srst always reads back as zero
	always_comb begin
		rd_mapped = 1'b1;
		case (s_axi_araddr)
			eth_regs_pkg::REG_CTRL: rd_word = {{(eth_regs_pkg::DATA_WIDTH-1){1'b0}}, enable};
			eth_regs_pkg::REG_SAMPLE_PERIOD: rd_word = sample_period;
			eth_regs_pkg::REG_OVERFLOW_LO: rd_word = overflow_count[31:0];
			eth_regs_pkg::REG_OVERFLOW_HI: rd_word = overflow_count[63:32];
			eth_regs_pkg::REG_TX_BYTES_LO: rd_word = tx_stats.total_bytes[31:0];
			eth_regs_pkg::REG_TX_BYTES_HI: rd_word = tx_stats.total_bytes[63:32];
			eth_regs_pkg::REG_TX_GOOD_LO: rd_word = tx_stats.total_good[31:0];
			eth_regs_pkg::REG_TX_GOOD_HI: rd_word = tx_stats.total_good[63:32];
			eth_regs_pkg::REG_TX_BAD_LO: rd_word = tx_stats.total_bad[31:0];
			eth_regs_pkg::REG_TX_BAD_HI: rd_word = tx_stats.total_bad[63:32];
			eth_regs_pkg::REG_RX_BYTES_LO: rd_word = rx_stats.total_bytes[31:0];
			eth_regs_pkg::REG_RX_BYTES_HI: rd_word = rx_stats.total_bytes[63:32];
			eth_regs_pkg::REG_RX_GOOD_LO: rd_word = rx_stats.total_good[31:0];
			eth_regs_pkg::REG_RX_GOOD_HI: rd_word = rx_stats.total_good[63:32];
			eth_regs_pkg::REG_RX_BAD_LO: rd_word = rx_stats.total_bad[31:0];
			eth_regs_pkg::REG_RX_BAD_HI: rd_word = rx_stats.total_bad[63:32];
			default: begin
				rd_word = '0;
				rd_mapped = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_state <= eth_regs_pkg::BUS_IDLE;
		end else if (rd_accept) begin
			rd_state <= eth_regs_pkg::BUS_RESP;
		end else if (s_axi_rvalid && s_axi_rready) begin
			rd_state <= eth_regs_pkg::BUS_IDLE;
		end
	end

	// Sampled on accept and held through the response
	always_ff @(posedge clk) begin
		if (rd_accept) begin
			s_axi_rdata <= rd_word;
			s_axi_rresp <= rd_mapped ? eth_regs_pkg::RESP_OKAY : eth_regs_pkg::RESP_SLVERR;
		end
	end

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata));

endmodule

// ==== verification/stats_input.txt ====
# Numbers are hex. T len | R len err | W addr data | E addr expected_rdata
# P checks the next log record against the model
E 010 0
E 018 0
E 028 0
E 038 0
E 008 0
# Length rule on tx, then tuser verdict on rx
W 000 1
T 3B
P
T 3C
P
T 5EA
P
T 5EB
P
E 010 C4C
E 014 0
E 018 2
E 020 2
R 40 0
P
R 80 1
P
E 028 C0
E 030 1
E 038 1
# Counting disabled
W 000 0
T 40
R 40 0
E 010 C4C
E 028 C0
E 000 0
# Back-to-back frames while the log sink stalls
W 000 1
T 40
T 40
T 40
E 010 D0C
E 008 2
P
E 018 5
# Software reset and an unmapped read
W 000 3
E 000 1
E 010 0
E 018 0
E 020 0
E 028 0
E 030 0
E 038 0
E 008 0
E 100 0
# Long sample period holds back the first record
W 004 800
W 000 3
T 5EA
T 5EA
P
E 010 BD4
E 004 800

// ==== verification/tb_clock_gen.sv ====
// Free-running 20 ns clock; rst_n is held low for the first 3 rising edges

`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== verification/tb_eth_stats.sv ====
// Runs from the project root; reads verification/stats_input.txt and keeps time_running high

`timescale 1ns/100ps

module tb_eth_stats;

	logic clk;
	logic rst_n;
	logic [63:0] current_time;
	logic time_running;
	logic [11:0] s_axi_awaddr;
	logic s_axi_awvalid;
	logic s_axi_awready;
	logic [31:0] s_axi_wdata;
	logic s_axi_wvalid;
	logic s_axi_wready;
	logic [1:0] s_axi_bresp;
	logic s_axi_bvalid;
	logic s_axi_bready;
	logic [11:0] s_axi_araddr;
	logic s_axi_arvalid;
	logic s_axi_arready;
	logic [31:0] s_axi_rdata;
	logic [1:0] s_axi_rresp;
	logic s_axi_rvalid;
	logic s_axi_rready;
	logic [63:0] m_axis_log_tdata;
	logic m_axis_log_tlast;
	logic m_axis_log_tvalid;
	logic m_axis_log_tready;
	logic axis_tx_tvalid;
	logic axis_tx_tready;
	logic axis_tx_tlast;
	logic axis_rx_tvalid;
	logic axis_rx_tlast;
	logic axis_rx_tuser;

	// Commands from the data file
	logic [7:0] op_q[$];
	logic [31:0] a_q[$];
	logic [31:0] b_q[$];
	logic [31:0] longest;
	int watchdog_cycles;
	integer seed;
	int checks;
	int value_errors;
	int other_errors;
	logic stray_seen;

	// Reference model
	logic model_en;
	logic [31:0] model_period;
	logic [63:0] tx_bytes, tx_good, tx_bad;
	logic [63:0] rx_bytes, rx_good, rx_bad;
	logic [63:0] timer_clear;
	logic log_busy;
	logic [63:0] exp_beat [5];

	tb_clock_gen u_clock_gen (
		.clk(clk),
		.rst_n(rst_n)
	);

	eth_stats_collector u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.current_time(current_time),
		.time_running(time_running),
		.s_axi_awaddr(s_axi_awaddr),
		.s_axi_awvalid(s_axi_awvalid),
		.s_axi_awready(s_axi_awready),
		.s_axi_wdata(s_axi_wdata),
		.s_axi_wvalid(s_axi_wvalid),
		.s_axi_wready(s_axi_wready),
		.s_axi_bresp(s_axi_bresp),
		.s_axi_bvalid(s_axi_bvalid),
		.s_axi_bready(s_axi_bready),
		.s_axi_araddr(s_axi_araddr),
		.s_axi_arvalid(s_axi_arvalid),
		.s_axi_arready(s_axi_arready),
		.s_axi_rdata(s_axi_rdata),
		.s_axi_rresp(s_axi_rresp),
		.s_axi_rvalid(s_axi_rvalid),
		.s_axi_rready(s_axi_rready),
		.m_axis_log_tdata(m_axis_log_tdata),
		.m_axis_log_tlast(m_axis_log_tlast),
		.m_axis_log_tvalid(m_axis_log_tvalid),
		.m_axis_log_tready(m_axis_log_tready),
		.axis_tx_tvalid(axis_tx_tvalid),
		.axis_tx_tready(axis_tx_tready),
		.axis_tx_tlast(axis_tx_tlast),
		.axis_rx_tvalid(axis_rx_tvalid),
		.axis_rx_tlast(axis_rx_tlast),
		.axis_rx_tuser(axis_rx_tuser)
	);

	// Time base, one tick per cycle
	always @(posedge clk) begin
		current_time <= current_time + 1'b1;
	end

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			value_errors++;
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, expected);
		end
	endtask

	task automatic report_and_finish();
		$display("Checks: %0d, value mismatches: %0d, other errors: %0d",
			checks, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	endtask

	// Register map spans 0x000 to 0x03C, word aligned
	function automatic logic [1:0] expected_resp(input logic [11:0] addr);
		if (addr <= eth_regs_pkg::REG_RX_BAD_HI && addr[1:0] == 2'b00) begin
			return eth_regs_pkg::RESP_OKAY;
		end
		return eth_regs_pkg::RESP_SLVERR;
	endfunction

	task automatic load_commands();
		integer fd;
		integer code;
		logic [7:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [8*160-1:0] rest;
		fd = $fopen("verification/stats_input.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Cannot open verification/stats_input.txt");
			return;
		end
		while (!$feof(fd)) begin
			op = 8'h00;
			a = '0;
			b = '0;
			code = $fscanf(fd, " %c", op);
			if (code == 1 && op == "#") begin
				code = $fgets(rest, fd);
			end else if (code == 1) begin
				if (op == "T" || op == "R" || op == "W" || op == "E") begin
					code = $fscanf(fd, "%h", a);
				end
				if (op == "R" || op == "W" || op == "E") begin
					code = $fscanf(fd, "%h", b);
				end
				if ((op == "T" || op == "R") && a > longest) begin
					longest = a;
				end
				op_q.push_back(op);
				a_q.push_back(a);
				b_q.push_back(b);
			end
		end
		$fclose(fd);
	endtask

	// Adder rule, then record start if the logger is free and the period has run out
	task automatic count_frame(input logic is_rx, input logic [31:0] len, input logic good,
		input logic [63:0] end_time);
		if (!model_en) begin
			return;
		end
		if (is_rx) begin
			rx_bytes = rx_bytes + len;
			if (good) rx_good = rx_good + 1;
			else rx_bad = rx_bad + 1;
		end else begin
			tx_bytes = tx_bytes + len;
			if (good) tx_good = tx_good + 1;
			else tx_bad = tx_bad + 1;
		end
		// Trigger sees the timer three cycles after the last beat
		if (!log_busy && (end_time + 2 - timer_clear) >= model_period) begin
			log_busy = 1'b1;
			timer_clear = end_time + 4;
			exp_beat[0] = end_time + 4;
			exp_beat[1] = tx_bytes;
			exp_beat[2] = {tx_good[31:0], tx_bad[31:0]};
			exp_beat[3] = rx_bytes;
			exp_beat[4] = {rx_good[31:0], rx_bad[31:0]};
		end
	endtask

	task automatic send_frame(input logic is_rx, input logic [31:0] len, input logic err);
		logic [63:0] end_time;
		logic last;
		logic stall;
		integer beat_i;
		end_time = '0;
		beat_i = 0;
		while (beat_i < len) begin
			@(posedge clk);
			last = (beat_i == len - 1);
			end_time = current_time;
			if (is_rx) begin
				axis_rx_tvalid <= 1'b1;
				axis_rx_tlast <= last;
				axis_rx_tuser <= err && last;
				beat_i++;
			end else begin
				// Random ready gaps hold the beat for another cycle
				stall = ($random(seed) & 7) == 0;
				axis_tx_tvalid <= 1'b1;
				axis_tx_tready <= !stall;
				axis_tx_tlast <= last;
				if (!stall) begin
					beat_i++;
				end
			end
		end
		@(posedge clk);
		axis_tx_tvalid <= 1'b0;
		axis_tx_tready <= 1'b1;
		axis_tx_tlast <= 1'b0;
		axis_rx_tvalid <= 1'b0;
		axis_rx_tlast <= 1'b0;
		axis_rx_tuser <= 1'b0;
		if (is_rx) begin
			count_frame(1'b1, len, !err, end_time);
		end else begin
			count_frame(1'b0, len, (len >= eth_stats_pkg::MIN_FRAME_LEN) &&
				(len <= eth_stats_pkg::MAX_FRAME_LEN), end_time);
		end
	endtask

	task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
		logic [63:0] accept_time;
		@(posedge clk);
		s_axi_awaddr <= addr;
		s_axi_wdata <= data;
		s_axi_awvalid <= 1'b1;
		s_axi_wvalid <= 1'b1;
		@(posedge clk);
		while (!s_axi_awready) @(posedge clk);
		compare_value("s_axi_wready", s_axi_wready, 1'b1);
		accept_time = current_time;
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid <= 1'b0;
		s_axi_bready <= 1'b1;
		@(posedge clk);
		while (!s_axi_bvalid) @(posedge clk);
		s_axi_bready <= 1'b0;
		compare_value("s_axi_bresp", s_axi_bresp, expected_resp(addr));
		if (addr == eth_regs_pkg::REG_CTRL) begin
			model_en = data[0];
			if (data[1]) begin
				{tx_bytes, tx_good, tx_bad} = '0;
				{rx_bytes, rx_good, rx_bad} = '0;
				timer_clear = accept_time + 1;
			end
		end
		if (addr == eth_regs_pkg::REG_SAMPLE_PERIOD) begin
			model_period = data;
		end
	endtask

	task automatic bus_read_check(input logic [11:0] addr, input logic [31:0] expected);
		@(posedge clk);
		s_axi_araddr <= addr;
		s_axi_arvalid <= 1'b1;
		s_axi_rready <= 1'b1;
		@(posedge clk);
		while (!s_axi_arready) @(posedge clk);
		s_axi_arvalid <= 1'b0;
		@(posedge clk);
		while (!s_axi_rvalid) @(posedge clk);
		s_axi_rready <= 1'b0;
		compare_value($sformatf("s_axi_rdata at 0x%h", addr), s_axi_rdata, expected);
		compare_value($sformatf("s_axi_rresp at 0x%h", addr), s_axi_rresp, expected_resp(addr));
	endtask

	// Drains one record with random ready gaps
	task automatic check_record();
		int idx;
		if (!log_busy) begin
			other_errors++;
			$display("Log record requested but the model expects none");
			return;
		end
		idx = 0;
		while (idx < eth_stats_pkg::LOG_BEATS) begin
			@(posedge clk);
			if (m_axis_log_tvalid && m_axis_log_tready) begin
				compare_value($sformatf("m_axis_log_tdata beat %0d", idx),
					m_axis_log_tdata, exp_beat[idx]);
				compare_value("m_axis_log_tlast", m_axis_log_tlast,
					idx == eth_stats_pkg::LOG_BEATS - 1);
				idx++;
			end
			if (idx < eth_stats_pkg::LOG_BEATS) begin
				m_axis_log_tready <= ($random(seed) & 3) != 0;
			end else begin
				m_axis_log_tready <= 1'b0;
			end
		end
		log_busy = 1'b0;
	endtask

	// A record the model did not predict
	always @(negedge clk) begin
		if (rst_n && m_axis_log_tvalid && !log_busy && !stray_seen) begin
			stray_seen = 1'b1;
			other_errors++;
			$display("Log stream became valid while no record was expected");
		end
	end

	initial begin
		wait (watchdog_cycles != 0);
		repeat (watchdog_cycles) @(posedge clk);
		other_errors++;
		$display("Timeout after %0d cycles, the run did not finish", watchdog_cycles);
		report_and_finish();
	end

	initial begin
		current_time = '0;
		time_running = 1'b1;
		s_axi_awaddr = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata = '0;
		s_axi_wvalid = 1'b0;
		s_axi_bready = 1'b0;
		s_axi_araddr = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready = 1'b0;
		m_axis_log_tready = 1'b0;
		axis_tx_tvalid = 1'b0;
		axis_tx_tready = 1'b1;
		axis_tx_tlast = 1'b0;
		axis_rx_tvalid = 1'b0;
		axis_rx_tlast = 1'b0;
		axis_rx_tuser = 1'b0;
		seed = 37;
		checks = 0;
		value_errors = 0;
		other_errors = 0;
		stray_seen = 1'b0;
		longest = '0;
		model_en = 1'b0;
		model_period = '0;
		{tx_bytes, tx_good, tx_bad} = '0;
		{rx_bytes, rx_good, rx_bad} = '0;
		timer_clear = '0;
		log_busy = 1'b0;
		load_commands();
		// Tx ready gaps can stretch a frame
		watchdog_cycles = (op_q.size() + 1) * (2 * longest + 64) + 200;
		wait (rst_n === 1'b1);
		@(posedge clk);
		compare_value("s_axi_awready", s_axi_awready, 1'b0);
		compare_value("s_axi_wready", s_axi_wready, 1'b0);
		compare_value("s_axi_arready", s_axi_arready, 1'b0);
		compare_value("s_axi_bvalid", s_axi_bvalid, 1'b0);
		compare_value("s_axi_rvalid", s_axi_rvalid, 1'b0);
		compare_value("m_axis_log_tvalid", m_axis_log_tvalid, 1'b0);
		// Every counter word reads zero after reset
		for (int reg_addr = 'h008; reg_addr <= 'h03C; reg_addr += 4) begin
			bus_read_check(reg_addr[11:0], '0);
		end
		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				"T": send_frame(1'b0, a_q[i], 1'b0);
				"R": send_frame(1'b1, a_q[i], b_q[i][0]);
				"W": bus_write(a_q[i][11:0], b_q[i]);
				"E": bus_read_check(a_q[i][11:0], b_q[i]);
				"P": check_record();
				default: begin
					other_errors++;
					$display("Unknown command %c in the stimulus file", op_q[i]);
				end
			endcase
		end
		report_and_finish();
	end

endmodule
